// File: logic/montmul_pkg.sv
package montmul_pkg;

    ////////////////////////////////////////////////////////////
    // Datapath sizes
    ////////////////////////////////////////////////////////////
    localparam int LIMB_W_DEF    = 8;
    localparam int NUM_LIMBS_DEF = 4;
    // Headroom for products piling up in one redundant column
    localparam int COL_GUARD     = 4;
    localparam int SEQ_W         = 8;
    localparam int APB_ADDR_W    = 8;
    localparam int APB_DATA_W    = 32;

    // Odd modulus, small enough that 4*MODULUS stays below R
    localparam logic [31:0] MODULUS = 32'd1000000007;

    ////////////////////////////////////////////////////////////
    // Montgomery constant
    ////////////////////////////////////////////////////////////
    // Returns -MODULUS^-1 mod 2^limb_w
    function automatic logic [63:0] mont_minv(input int limb_w);
        logic [63:0] inv;
        logic [63:0] mask;
        // Newton steps start from m itself, already exact mod 8
        inv = 64'(MODULUS);
        for (int i = 0; i < 5; i++) begin
            inv = inv * (64'd2 - 64'(MODULUS) * inv);
        end
        mask = (64'd1 << limb_w) - 64'd1;
        return (~inv + 64'd1) & mask;
    endfunction

    // Register map
    typedef enum logic [APB_ADDR_W-1:0] {
        OPA    = 8'h00,
        OPB    = 8'h04,
        CTRL   = 8'h08,
        STATUS = 8'h0C,
        RESULT = 8'h10
    } reg_addr_e;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } dec_state_e;

endpackage

// File: logic/montmul_if.sv
// One operation handed from the register block to the array
interface mm_issue_if import montmul_pkg::*; #(
    parameter int LIMB_W    = LIMB_W_DEF,
    parameter int NUM_LIMBS = NUM_LIMBS_DEF
);
    logic                        valid;
    logic [LIMB_W*NUM_LIMBS-1:0] a;
    logic [LIMB_W*NUM_LIMBS-1:0] b;
    logic [SEQ_W-1:0]            seq;

    modport issue   (output valid, a, b, seq);
    modport receive (input  valid, a, b, seq);
endinterface

// Redundant columns leaving the last array row
interface mm_sum_if import montmul_pkg::*; #(
    parameter int LIMB_W    = LIMB_W_DEF,
    parameter int NUM_LIMBS = NUM_LIMBS_DEF
);
    localparam int COL_W = 2 * LIMB_W + COL_GUARD;

    logic                              valid;
    logic [NUM_LIMBS:0][COL_W-1:0]     cols;
    // High part of column 0, whose low limb is always zero
    logic [COL_W-LIMB_W-1:0]           carry_lo;
    logic [SEQ_W-1:0]                  seq;

    modport drive   (output valid, cols, carry_lo, seq);
    modport receive (input  valid, cols, carry_lo, seq);
endinterface

// File: logic/mm_apb_decode.sv
module mm_apb_decode import montmul_pkg::*; #(
    parameter int LIMB_W    = LIMB_W_DEF,
    parameter int NUM_LIMBS = NUM_LIMBS_DEF
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [APB_ADDR_W-1:0]       paddr,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [APB_DATA_W-1:0]       pwdata,
    output logic [APB_DATA_W-1:0]       prdata,
    output logic                        pready,
    output logic                        pslverr,
    mm_issue_if.issue                   issue,
    input  logic [LIMB_W*NUM_LIMBS-1:0] result_z,
    input  logic                        done,
    input  logic [SEQ_W-1:0]            done_seq
);

    localparam int OP_W = LIMB_W * NUM_LIMBS;

    dec_state_e            state;
    dec_state_e            phase;
    logic                  xfer;
    logic                  addr_ok;
    logic                  start_req;
    logic                  start_ok;
    logic                  busy;
    logic [OP_W-1:0]       opa;
    logic [OP_W-1:0]       opb;
    logic [SEQ_W-1:0]      seq_cnt;
    logic [APB_DATA_W-1:0] status;

    // No wait states
    assign pready = 1'b1;

    ////////////////////////////////////////////////////////////
    // APB phase tracking
    ////////////////////////////////////////////////////////////
    always_comb begin
        if (!psel) begin
            phase = IDLE;
        end else if (penable) begin
            phase = ACCESS;
        end else begin
            phase = SETUP;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= phase;
        end
    end

    // Access phase that follows a proper setup phase
    assign xfer = (phase == ACCESS) && (state == SETUP);

    assign start_req = xfer && pwrite && (paddr == CTRL) && pwdata[0];
    assign start_ok  = start_req && !busy;
    assign pslverr   = xfer && (!addr_ok || (start_req && busy));

    ////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            opa         <= '0;
            opb         <= '0;
            seq_cnt     <= '0;
            busy        <= 1'b0;
            issue.valid <= 1'b0;
        end else begin
            if (xfer && pwrite && (paddr == OPA)) begin
                opa <= OP_W'(pwdata);
            end
            if (xfer && pwrite && (paddr == OPB)) begin
                opb <= OP_W'(pwdata);
            end
            if (start_ok) begin
                seq_cnt <= seq_cnt + 1'b1;
            end
            // Setting wins over a stale done from the previous operation
            if (start_ok) begin
                busy <= 1'b1;
            end else if (done && (done_seq == seq_cnt)) begin
                busy <= 1'b0;
            end
            issue.valid <= start_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (start_ok) begin
            issue.a   <= opa;
            issue.b   <= opb;
            issue.seq <= seq_cnt + 1'b1;
        end
    end

    // Busy in bit 0, done in bit 1, count in 15:8
    assign status = APB_DATA_W'({seq_cnt, 6'd0, done, busy});

    always_comb begin
        prdata  = '0;
        addr_ok = 1'b1;
        case (reg_addr_e'(paddr))
            OPA:     prdata = APB_DATA_W'(opa);
            OPB:     prdata = APB_DATA_W'(opb);
            CTRL:    prdata = '0;
            STATUS:  prdata = status;
            RESULT:  prdata = APB_DATA_W'(result_z);
            default: addr_ok = 1'b0;
        endcase
    end

endmodule

// File: logic/mm_row_pe.sv
module mm_row_pe import montmul_pkg::*; #(
    parameter int LIMB_W    = LIMB_W_DEF,
    parameter int NUM_LIMBS = NUM_LIMBS_DEF
) (
    input  logic                                         clk,
    input  logic [LIMB_W*NUM_LIMBS-1:0]                  a_in,
    input  logic [LIMB_W-1:0]                            b_limb,
    input  logic [NUM_LIMBS:0][2*LIMB_W+COL_GUARD-1:0]   cols_in,
    input  logic                                         valid_in,
    output logic [NUM_LIMBS:0][2*LIMB_W+COL_GUARD-1:0]   cols_out,
    output logic                                         valid_out
);

    localparam int               COL_W  = 2 * LIMB_W + COL_GUARD;
    localparam int               OP_W   = LIMB_W * NUM_LIMBS;
    localparam logic [OP_W-1:0]  MOD_OP = OP_W'(MODULUS);
    localparam logic [LIMB_W-1:0] M_INV = LIMB_W'(mont_minv(LIMB_W));

    logic [COL_W-1:0]                  low_col;
    logic [LIMB_W-1:0]                 q;
    logic [NUM_LIMBS-1:0][COL_W-1:0]   sum_next;

    // Column 0 is the pending column. Its high part still belongs at
    // weight 2^0 and its low limb was cleared by the previous row
    always_comb begin
        low_col = cols_in[0][COL_W-1:LIMB_W] + cols_in[1] + a_in[LIMB_W-1:0] * b_limb;
        // Quotient that zeroes the low limb
        q = low_col[LIMB_W-1:0] * M_INV;
        sum_next[0] = low_col + q * MOD_OP[LIMB_W-1:0];
        for (int j = 1; j < NUM_LIMBS; j++) begin
            sum_next[j] = cols_in[j+1]
                        + a_in[j*LIMB_W +: LIMB_W] * b_limb
                        + q * MOD_OP[j*LIMB_W +: LIMB_W];
        end
    end

    // Shift down one limb; top column fills with zero
    always_ff @(posedge clk) begin
        cols_out[NUM_LIMBS-1:0] <= sum_next;
        cols_out[NUM_LIMBS]     <= '0;
        valid_out               <= valid_in;
    end

endmodule

// File: logic/mm_systolic_execute.sv
module mm_systolic_execute import montmul_pkg::*; #(
    parameter int LIMB_W    = LIMB_W_DEF,
    parameter int NUM_LIMBS = NUM_LIMBS_DEF
) (
    input  logic        clk,
    input  logic        rst_n,
    mm_issue_if.receive issue,
    mm_sum_if.drive     sums
);

    localparam int COL_W = 2 * LIMB_W + COL_GUARD;
    localparam int OP_W  = LIMB_W * NUM_LIMBS;

    logic                               ent_vld;
    logic [NUM_LIMBS-1:0][OP_W-1:0]     a_pipe;
    logic [NUM_LIMBS-1:0][OP_W-1:0]     b_pipe;
    logic [NUM_LIMBS:0][SEQ_W-1:0]      seq_pipe;
    logic [NUM_LIMBS:0][COL_W-1:0]      col_chain [NUM_LIMBS+1];
    logic                               vld_chain [NUM_LIMBS+1];

    ////////////////////////////////////////////////////////////
    // Entry registers and operand delay lines
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ent_vld <= 1'b0;
        end else begin
            ent_vld <= issue.valid;
        end
    end

    // Index 0 is the entry stage, each later index one row further
    always_ff @(posedge clk) begin
        a_pipe[0]   <= issue.a;
        b_pipe[0]   <= issue.b;
        seq_pipe[0] <= issue.seq;
        for (int i = 1; i < NUM_LIMBS; i++) begin
            a_pipe[i] <= a_pipe[i-1];
            // Drop the limb the previous row consumed
            b_pipe[i] <= b_pipe[i-1] >> LIMB_W;
        end
        for (int i = 1; i <= NUM_LIMBS; i++) begin
            seq_pipe[i] <= seq_pipe[i-1];
        end
    end

    assign col_chain[0] = '0;
    assign vld_chain[0] = ent_vld;

    ////////////////////////////////////////////////////////////
    // Row chain
    ////////////////////////////////////////////////////////////
    for (genvar i = 0; i < NUM_LIMBS; i++) begin : g_row
        mm_row_pe #(
            .LIMB_W    (LIMB_W),
            .NUM_LIMBS (NUM_LIMBS)
        ) u_row (
            .clk       (clk),
            .a_in      (a_pipe[i]),
            .b_limb    (b_pipe[i][LIMB_W-1:0]),
            .cols_in   (col_chain[i]),
            .valid_in  (vld_chain[i]),
            .cols_out  (col_chain[i+1]),
            .valid_out (vld_chain[i+1])
        );
    end

    assign sums.valid    = vld_chain[NUM_LIMBS];
    assign sums.cols     = col_chain[NUM_LIMBS];
    assign sums.carry_lo = col_chain[NUM_LIMBS][0][COL_W-1:LIMB_W];
    assign sums.seq      = seq_pipe[NUM_LIMBS];

endmodule

// File: logic/mm_final_result.sv
module mm_final_result import montmul_pkg::*; #(
    parameter int LIMB_W    = LIMB_W_DEF,
    parameter int NUM_LIMBS = NUM_LIMBS_DEF
) (
    input  logic                        clk,
    input  logic                        rst_n,
    mm_sum_if.receive                   sums,
    output logic [LIMB_W*NUM_LIMBS-1:0] result_z,
    output logic                        done,
    output logic [SEQ_W-1:0]            done_seq,
    input  logic                        start_accepted
);

    localparam int              COL_W  = 2 * LIMB_W + COL_GUARD;
    localparam int              OP_W   = LIMB_W * NUM_LIMBS;
    localparam int              FOLD_W = OP_W + COL_W;
    localparam logic [OP_W-1:0] MOD_OP = OP_W'(MODULUS);

    logic [FOLD_W-1:0] fold_sum;
    logic [OP_W-1:0]   fold_z;
    logic [OP_W-1:0]   z_sub;
    logic              fold_vld;
    logic [SEQ_W-1:0]  fold_seq;

    // Columns 1..N sit at limb weights 0..N-1, carry_lo at weight 1
    always_comb begin
        fold_sum = FOLD_W'(sums.carry_lo);
        for (int j = 1; j <= NUM_LIMBS; j++) begin
            fold_sum = fold_sum + (FOLD_W'(sums.cols[j]) << (LIMB_W * (j - 1)));
        end
    end

    ////////////////////////////////////////////////////////////
    // Fold stage
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fold_vld <= 1'b0;
        end else begin
            fold_vld <= sums.valid;
        end
    end

    // Value is below 2*MODULUS so it fits the operand width
    always_ff @(posedge clk) begin
        fold_z   <= fold_sum[OP_W-1:0];
        fold_seq <= sums.seq;
    end

    assign z_sub = fold_z - MOD_OP;

    // Subtract and register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_z <= '0;
            done     <= 1'b0;
            done_seq <= '0;
        end else begin
            if (fold_vld) begin
                result_z <= (fold_z >= MOD_OP) ? z_sub : fold_z;
                done_seq <= fold_seq;
            end
            if (start_accepted) begin
                done <= 1'b0;
            end else if (fold_vld) begin
                done <= 1'b1;
            end
        end
    end

endmodule

// File: logic/montmul_top.sv
module montmul_top import montmul_pkg::*; #(
    parameter int LIMB_W    = LIMB_W_DEF,
    parameter int NUM_LIMBS = NUM_LIMBS_DEF
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [APB_ADDR_W-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [APB_DATA_W-1:0] pwdata,
    output logic [APB_DATA_W-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr
);

    logic [LIMB_W*NUM_LIMBS-1:0] result_z;
    logic                        done;
    logic [SEQ_W-1:0]            done_seq;

    mm_issue_if #(.LIMB_W(LIMB_W), .NUM_LIMBS(NUM_LIMBS)) issue_bus ();
    mm_sum_if   #(.LIMB_W(LIMB_W), .NUM_LIMBS(NUM_LIMBS)) sum_bus ();

    mm_apb_decode #(.LIMB_W(LIMB_W), .NUM_LIMBS(NUM_LIMBS)) u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .issue    (issue_bus.issue),
        .result_z (result_z),
        .done     (done),
        .done_seq (done_seq)
    );

    mm_systolic_execute #(.LIMB_W(LIMB_W), .NUM_LIMBS(NUM_LIMBS)) u_execute (
        .clk   (clk),
        .rst_n (rst_n),
        .issue (issue_bus.receive),
        .sums  (sum_bus.drive)
    );

    // The issue pulse marks an accepted start and clears the old done
    mm_final_result #(.LIMB_W(LIMB_W), .NUM_LIMBS(NUM_LIMBS)) u_result (
        .clk            (clk),
        .rst_n          (rst_n),
        .sums           (sum_bus.receive),
        .result_z       (result_z),
        .done           (done),
        .done_seq       (done_seq),
        .start_accepted (issue_bus.valid)
    );

endmodule

// File: testbench/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

    // Release on a falling edge, away from the register updates
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: testbench/montmul_tb.sv
module montmul_tb import montmul_pkg::*; ();

    localparam int LIMB_W        = LIMB_W_DEF;
    localparam int NUM_LIMBS     = NUM_LIMBS_DEF;
    localparam int OP_W          = LIMB_W * NUM_LIMBS;
    localparam int NUM_TESTS     = 10;
    localparam int POLL_LIMIT    = NUM_LIMBS + 30;
    localparam int WATCHDOG_TIME = NUM_TESTS * (NUM_LIMBS + 30) * 10 * 4;

    logic                  clk;
    logic                  rst_n;
    logic [APB_ADDR_W-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_DATA_W-1:0] pwdata;
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;

    // Stimulus table with expected results
    string       tbl_name [NUM_TESTS];
    logic [31:0] tbl_a    [NUM_TESTS];
    logic [31:0] tbl_b    [NUM_TESTS];
    logic [31:0] tbl_z    [NUM_TESTS];

    integer           seed;
    logic [SEQ_W-1:0] exp_seq;

    tb_clock_gen u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    montmul_top #(.LIMB_W(LIMB_W), .NUM_LIMBS(NUM_LIMBS)) UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    ////////////////////////////////////////////////////////////
    // Reference model and checking
    ////////////////////////////////////////////////////////////
    // Bit-serial Montgomery reduction of the full product
    function automatic logic [31:0] ref_montmul(input logic [31:0] a, input logic [31:0] b);
        logic [63:0] t;
        t = 64'(a) * 64'(b);
        for (int i = 0; i < OP_W; i++) begin
            if (t[0]) begin
                t = t + 64'(MODULUS);
            end
            t = t >> 1;
        end
        if (t >= 64'(MODULUS)) begin
            t = t - 64'(MODULUS);
        end
        return t[31:0];
    endfunction

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL %s expected 0x%08h actual 0x%08h", name, expected, actual);
            abort_run();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // APB access tasks
    ////////////////////////////////////////////////////////////
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        @(negedge clk);
        paddr   = addr;
        pwrite  = 1'b1;
        pwdata  = data;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        // Mid low phase, well clear of the rising edge
        #2;
        err = pslverr;
        check_value("APB write pready", 32'd1, 32'(pready));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        @(negedge clk);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #2;
        data = prdata;
        err  = pslverr;
        check_value("APB read pready", 32'd1, 32'(pready));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_reg(input string name, input logic [7:0] addr,
                             input logic [31:0] data);
        logic err;
        apb_write(addr, data, err);
        check_value({name, " pslverr"}, 32'd0, 32'(err));
    endtask

    task automatic read_reg(input string name, input logic [7:0] addr,
                            output logic [31:0] data);
        logic err;
        apb_read(addr, data, err);
        check_value({name, " pslverr"}, 32'd0, 32'(err));
    endtask

    // Poll STATUS until done is set and busy has dropped
    task automatic wait_for_done(input string name);
        logic [31:0] st_word;
        logic        finished;
        int          polls;
        finished = 1'b0;
        polls    = 0;
        while (!finished && polls < POLL_LIMIT) begin
            read_reg({name, " poll"}, STATUS, st_word);
            finished = st_word[1] && !st_word[0];
            polls++;
        end
        if (!finished) begin
            $display("Operation %s did not finish within %0d STATUS polls", name, POLL_LIMIT);
            abort_run();
        end
    endtask

    task automatic run_operation(input string name, input logic [31:0] a,
                                 input logic [31:0] b, input logic [31:0] z);
        logic [31:0] rdata;
        write_reg({name, " OPA"}, OPA, a);
        write_reg({name, " OPB"}, OPB, b);
        write_reg({name, " start"}, CTRL, 32'd1);
        exp_seq = exp_seq + 1'b1;
        read_reg({name, " STATUS"}, STATUS, rdata);
        check_value({name, " busy after start"}, 32'd1, 32'(rdata[0]));
        check_value({name, " done after start"}, 32'd0, 32'(rdata[1]));
        wait_for_done(name);
        read_reg({name, " STATUS"}, STATUS, rdata);
        check_value({name, " busy at end"}, 32'd0, 32'(rdata[0]));
        check_value({name, " done at end"}, 32'd1, 32'(rdata[1]));
        check_value({name, " seq count"}, 32'(exp_seq), 32'(rdata[15:8]));
        read_reg({name, " RESULT"}, RESULT, rdata);
        check_value({name, " RESULT"}, z, rdata);
    endtask

    task automatic build_table();
        logic [31:0] r_mod;
        r_mod = 32'((64'd1 << OP_W) % 64'(MODULUS));
        tbl_name[0] = "zero";
        tbl_a[0]    = 32'd0;
        tbl_b[0]    = 32'd123456789;
        tbl_name[1] = "one";
        tbl_a[1]    = 32'd1;
        tbl_b[1]    = 32'd1;
        tbl_name[2] = "max";
        tbl_a[2]    = MODULUS - 1;
        tbl_b[2]    = MODULUS - 1;
        tbl_name[3] = "r_mod";
        tbl_a[3]    = r_mod;
        tbl_b[3]    = 32'd987654321;
        tbl_name[4] = "r_squared";
        tbl_a[4]    = r_mod;
        tbl_b[4]    = r_mod;
        tbl_name[5] = "one_by_max";
        tbl_a[5]    = 32'd1;
        tbl_b[5]    = MODULUS - 1;
        for (int i = 6; i < NUM_TESTS; i++) begin
            tbl_name[i] = $sformatf("random_%0d", i);
            tbl_a[i]    = {$random(seed)} % MODULUS;
            tbl_b[i]    = {$random(seed)} % MODULUS;
        end
        for (int i = 0; i < NUM_TESTS; i++) begin
            tbl_z[i] = ref_montmul(tbl_a[i], tbl_b[i]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////
    initial begin : main
        logic [31:0] rdata;
        logic        err;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        seed    = 23301;
        exp_seq = '0;
        build_table();
        wait (rst_n === 1'b1);
        #2;
        check_value("reset pslverr", 32'd0, 32'(pslverr));
        read_reg("reset STATUS", STATUS, rdata);
        check_value("reset STATUS", 32'd0, rdata);
        read_reg("reset RESULT", RESULT, rdata);
        check_value("reset RESULT", 32'd0, rdata);
        read_reg("reset OPA", OPA, rdata);
        check_value("reset OPA", 32'd0, rdata);
        read_reg("reset OPB", OPB, rdata);
        check_value("reset OPB", 32'd0, rdata);

        // Operand readback
        write_reg("readback OPA", OPA, 32'h1234_5678);
        write_reg("readback OPB", OPB, 32'h0BAD_F00D);
        read_reg("readback OPA", OPA, rdata);
        check_value("readback OPA", 32'h1234_5678, rdata);
        read_reg("readback OPB", OPB, rdata);
        check_value("readback OPB", 32'h0BAD_F00D, rdata);

        for (int i = 0; i < NUM_TESTS; i++) begin
            run_operation(tbl_name[i], tbl_a[i], tbl_b[i], tbl_z[i]);
        end

        // Second start lands while the first is still in the array
        write_reg("busy OPA", OPA, tbl_a[3]);
        write_reg("busy OPB", OPB, tbl_b[3]);
        write_reg("busy start", CTRL, 32'd1);
        exp_seq = exp_seq + 1'b1;
        // Different operand that a wrongly accepted start would pick up
        write_reg("busy new OPA", OPA, 32'd1);
        apb_write(CTRL, 32'd1, err);
        check_value("start while busy pslverr", 32'd1, 32'(err));
        wait_for_done("start while busy");
        read_reg("busy STATUS", STATUS, rdata);
        check_value("busy seq count", 32'(exp_seq), 32'(rdata[15:8]));
        read_reg("busy RESULT", RESULT, rdata);
        check_value("busy RESULT", tbl_z[3], rdata);

        // Unmapped offsets
        apb_read(8'h14, rdata, err);
        check_value("unknown read pslverr", 32'd1, 32'(err));
        apb_write(8'h20, 32'hDEAD_BEEF, err);
        check_value("unknown write pslverr", 32'd1, 32'(err));

        $display("All checks passed");
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_TIME);
        $display("Watchdog expired after %0d time units before the tests ended", WATCHDOG_TIME);
        abort_run();
    end

endmodule

// File: montmul_top.f
logic/montmul_pkg.sv
logic/montmul_if.sv
logic/mm_apb_decode.sv
logic/mm_row_pe.sv
logic/mm_systolic_execute.sv
logic/mm_final_result.sv
logic/montmul_top.sv
testbench/tb_clock_gen.sv
testbench/montmul_tb.sv

// File: Makefile
# Verilator flow for the Montgomery multiplier

VERILATOR  ?= verilator
FILELIST   ?= montmul_top.f
TOP        ?= montmul_tb
RTL_TOP    ?= montmul_top
LINT_FLAGS ?= --lint-only --sv
SIM_FLAGS  ?= --binary --sv --timing
BUILD_DIR  ?= obj_dir

.PHONY: all lint sim clean

all: sim

# Lint the design on its own
lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# Build and run the testbench; $fatal gives a failing exit status
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
